// ==== source/id_remap_pkg.sv ====
package id_remap_pkg;

  // Forward and internal IDs share one width.
  localparam int ID_W = 4;

  // Largest pool the ID type can address.
  localparam int NUM_ID_MAX = 1 << ID_W;

  typedef logic [ID_W-1:0] id_t;     // fid or rid.

  // Free count or limit, 0 up to NUM_ID_MAX.
  typedef logic [ID_W:0] count_t;

endpackage

// ==== source/remap_reg_pkg.sv ====
package remap_reg_pkg;

  typedef logic [2:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // Register map.
  localparam reg_addr_t ADDR_CTRL   = 3'd0;  // Bit 0 enable.
  localparam reg_addr_t ADDR_LIMIT  = 3'd1;  // Outstanding-ID limit.
  localparam reg_addr_t ADDR_FREE   = 3'd2;  // Free count, RO.
  localparam reg_addr_t ADDR_GRANTS = 3'd3;  // Grant count, write clears.
  localparam reg_addr_t ADDR_BUSY   = 3'd4;  // Busy map, RO.

endpackage

// ==== source/id_mapper.sv ====
`timescale 1ns/1ps

module id_mapper #(
  parameter int NUM_ID = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  // Allocation side.
  input  logic                 map_req,
  input  id_remap_pkg::id_t    map_fid,
  output logic                 map_vld,
  output id_remap_pkg::id_t    map_rid,
  // Release ports.
  input  logic                 rel_0,
  input  logic                 rel_1,
  input  id_remap_pkg::id_t    rel_rid_0,
  input  id_remap_pkg::id_t    rel_rid_1,
  output logic                 rel_vld_0,
  output logic                 rel_vld_1,
  output id_remap_pkg::id_t    rel_fid_0,
  output id_remap_pkg::id_t    rel_fid_1,
  // Lookup, no side effect.
  input  id_remap_pkg::id_t    lkp_rid,
  output logic                 lkp_vld,
  output id_remap_pkg::id_t    lkp_fid,
  // Status.
  output id_remap_pkg::count_t free_cnt,
  output logic [NUM_ID-1:0]    id_bsy
);

  logic [NUM_ID-1:0]    bsy;
  logic [NUM_ID-1:0]    bsy_nxt;
  logic [NUM_ID-1:0]    mask;       // Rids above the last grant.
  logic [NUM_ID-1:0]    mask_nxt;
  id_remap_pkg::id_t    fid_tbl [NUM_ID];
  logic                 grant;
  logic                 offer_vld;
  id_remap_pkg::id_t    offer_rid;
  id_remap_pkg::count_t free_nxt;

  assign grant = map_req && map_vld;  // Offer taken this cycle.

  ////////////////////////////////////////////////////////////////////////////
  // Busy bits and rotation mask.
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    bsy_nxt = bsy;
    for (int i = 0; i < NUM_ID; i++) begin
      if (rel_0 && (rel_rid_0 == i))
        bsy_nxt[i] = 1'b0;  // Port 0 release.
      if (rel_1 && (rel_rid_1 == i))
        bsy_nxt[i] = 1'b0;  // Port 1 release.
      if (grant && (map_rid == i))
        bsy_nxt[i] = 1'b1;
    end
  end

  // Everything strictly above the rid granted now.
  always_comb begin
    mask_nxt = mask;
    if (grant)
      mask_nxt = ({NUM_ID{1'b1}} << map_rid) << 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next offer and free count, both from the next busy state.
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    offer_vld = 1'b0;
    offer_rid = '0;
    // First pass above the last grant.
    for (int i = 0; i < NUM_ID; i++) begin
      if (!offer_vld && mask_nxt[i] && !bsy_nxt[i]) begin
        offer_vld = 1'b1;
        offer_rid = id_remap_pkg::id_t'(i);
      end
    end
    // Wrap to the lowest free rid.
    for (int i = 0; i < NUM_ID; i++) begin
      if (!offer_vld && !bsy_nxt[i]) begin
        offer_vld = 1'b1;
        offer_rid = id_remap_pkg::id_t'(i);
      end
    end
  end

  always_comb begin
    free_nxt = '0;
    for (int i = 0; i < NUM_ID; i++)
      if (!bsy_nxt[i])
        free_nxt = free_nxt + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bsy      <= '0;
      mask     <= '1;  // Rid 0 first.
      map_vld  <= 1'b0;
      map_rid  <= '0;
      free_cnt <= id_remap_pkg::count_t'(NUM_ID);
    end else begin
      bsy      <= bsy_nxt;
      mask     <= mask_nxt;
      map_vld  <= offer_vld;
      map_rid  <= offer_rid;
      free_cnt <= free_nxt;
    end
  end

  // Rid-to-fid table.
  always_ff @(posedge clk) begin
    if (grant)
      fid_tbl[map_rid] <= map_fid;
  end

  // Release and lookup reads of the current state.
  assign rel_vld_0 = (rel_rid_0 < NUM_ID) && bsy[rel_rid_0];
  assign rel_fid_0 = fid_tbl[rel_rid_0];
  assign rel_vld_1 = (rel_rid_1 < NUM_ID) && bsy[rel_rid_1];
  assign rel_fid_1 = fid_tbl[rel_rid_1];
  assign lkp_vld   = (lkp_rid < NUM_ID) && bsy[lkp_rid];
  assign lkp_fid   = fid_tbl[lkp_rid];

  assign id_bsy = bsy;

endmodule

// ==== source/req_remapper.sv ====
`timescale 1ns/1ps

module req_remapper #(
  parameter int NUM_ID = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  // Upstream.
  input  logic                 req,
  input  id_remap_pkg::id_t    req_fid,
  output logic                 req_grant,
  // Steering from the register block.
  input  logic                 enable,
  input  id_remap_pkg::count_t limit,
  input  id_remap_pkg::count_t free_cnt,
  // Pool offer.
  input  logic                 map_vld,
  input  id_remap_pkg::id_t    map_rid,
  output logic                 map_req,
  output id_remap_pkg::id_t    map_fid,
  // Downstream.
  output logic                 out_vld,
  output id_remap_pkg::id_t    out_rid,
  output id_remap_pkg::id_t    out_fid
);

  id_remap_pkg::count_t outstanding;
  logic                 below_limit;

  ////////////////////////////////////////////////////////////////////////////
  // Grant decision.
  ////////////////////////////////////////////////////////////////////////////

  assign outstanding = id_remap_pkg::count_t'(NUM_ID) - free_cnt;
  assign below_limit = (outstanding < limit);

  assign req_grant = req && enable && map_vld && below_limit;

  assign map_req = req_grant;  // Pool takes the offer.
  assign map_fid = req_fid;

  // Downstream request, one cycle after grant.
  always_ff @(posedge clk) begin
    if (rst)
      out_vld <= 1'b0;
    else
      out_vld <= req_grant;
  end

  always_ff @(posedge clk) begin
    if (req_grant) begin
      out_rid <= map_rid;
      out_fid <= req_fid;
    end
  end

endmodule

// ==== source/remap_regs.sv ====
`timescale 1ns/1ps

module remap_regs #(
  parameter int NUM_ID = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  // Register bus.
  input  logic                     reg_wr,
  input  remap_reg_pkg::reg_addr_t reg_addr,
  input  remap_reg_pkg::reg_data_t reg_wdata,
  output remap_reg_pkg::reg_data_t reg_rdata,
  // Control out.
  output logic                     enable,
  output id_remap_pkg::count_t     limit,
  // Status in.
  input  logic                     req_grant,
  input  id_remap_pkg::count_t     free_cnt,
  input  logic [NUM_ID-1:0]        id_bsy
);

  remap_reg_pkg::reg_data_t grant_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      enable <= 1'b0;
      limit  <= id_remap_pkg::count_t'(NUM_ID);  // No limit by default.
    end else if (reg_wr) begin
      if (reg_addr == remap_reg_pkg::ADDR_CTRL)
        enable <= reg_wdata[0];
      if (reg_addr == remap_reg_pkg::ADDR_LIMIT)
        limit <= id_remap_pkg::count_t'(reg_wdata);
    end
  end

  // Grant counter. Wraps, write clears.
  always_ff @(posedge clk) begin
    if (rst)
      grant_cnt <= '0;
    else if (reg_wr && (reg_addr == remap_reg_pkg::ADDR_GRANTS))
      grant_cnt <= '0;  // Clear beats a same-cycle grant.
    else if (req_grant)
      grant_cnt <= grant_cnt + 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux, unused bits zero.
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (reg_addr)
      remap_reg_pkg::ADDR_CTRL:   reg_rdata = remap_reg_pkg::reg_data_t'(enable);
      remap_reg_pkg::ADDR_LIMIT:  reg_rdata = remap_reg_pkg::reg_data_t'(limit);
      remap_reg_pkg::ADDR_FREE:   reg_rdata = remap_reg_pkg::reg_data_t'(free_cnt);
      remap_reg_pkg::ADDR_GRANTS: reg_rdata = grant_cnt;
      remap_reg_pkg::ADDR_BUSY:   reg_rdata = remap_reg_pkg::reg_data_t'(id_bsy);
      default:                    reg_rdata = '0;
    endcase
  end

endmodule

// ==== source/id_remap_top.sv ====
`timescale 1ns/1ps

module id_remap_top #(
  parameter int NUM_ID = id_remap_pkg::NUM_ID_MAX
) (
  input  logic                     clk,
  input  logic                     rst,
  // Upstream requests.
  input  logic                     req,
  input  id_remap_pkg::id_t        req_fid,
  output logic                     req_grant,
  // Downstream requests.
  output logic                     out_vld,
  output id_remap_pkg::id_t        out_rid,
  output id_remap_pkg::id_t        out_fid,
  // Response ports.
  input  logic                     rsp_0,
  input  id_remap_pkg::id_t        rsp_rid_0,
  output logic                     rsp_vld_0,
  output id_remap_pkg::id_t        rsp_fid_0,
  input  logic                     rsp_1,
  input  id_remap_pkg::id_t        rsp_rid_1,
  output logic                     rsp_vld_1,
  output id_remap_pkg::id_t        rsp_fid_1,
  // Lookup.
  input  id_remap_pkg::id_t        lkp_rid,
  output logic                     lkp_vld,
  output id_remap_pkg::id_t        lkp_fid,
  // Register bus.
  input  logic                     reg_wr,
  input  remap_reg_pkg::reg_addr_t reg_addr,
  input  remap_reg_pkg::reg_data_t reg_wdata,
  output remap_reg_pkg::reg_data_t reg_rdata
);

  logic                 enable;
  id_remap_pkg::count_t limit;
  id_remap_pkg::count_t free_cnt;
  logic [NUM_ID-1:0]    id_bsy;
  logic                 map_req;
  id_remap_pkg::id_t    map_fid;
  logic                 map_vld;
  id_remap_pkg::id_t    map_rid;

  // Request path.
  req_remapper #(.NUM_ID(NUM_ID)) req_remapper_i (
    .clk, .rst,
    .req, .req_fid, .req_grant,
    .enable, .limit, .free_cnt,
    .map_vld, .map_rid, .map_req, .map_fid,
    .out_vld, .out_rid, .out_fid
  );

  // ID pool. Release ports serve the responses.
  id_mapper #(.NUM_ID(NUM_ID)) id_mapper_i (
    .clk, .rst,
    .map_req, .map_fid, .map_vld, .map_rid,
    .rel_0     (rsp_0),
    .rel_1     (rsp_1),
    .rel_rid_0 (rsp_rid_0),
    .rel_rid_1 (rsp_rid_1),
    .rel_vld_0 (rsp_vld_0),
    .rel_vld_1 (rsp_vld_1),
    .rel_fid_0 (rsp_fid_0),
    .rel_fid_1 (rsp_fid_1),
    .lkp_rid, .lkp_vld, .lkp_fid,
    .free_cnt, .id_bsy
  );

  // Control and status.
  remap_regs #(.NUM_ID(NUM_ID)) remap_regs_i (
    .clk, .rst,
    .reg_wr, .reg_addr, .reg_wdata, .reg_rdata,
    .enable, .limit,
    .req_grant, .free_cnt, .id_bsy
  );

endmodule

// ==== dv/id_remap_properties.sv ====
`timescale 1ns/1ps

module id_remap_properties #(
  parameter int NUM_ID = 16
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 map_req,
  input logic                 map_vld,
  input id_remap_pkg::id_t    map_rid,
  input id_remap_pkg::count_t free_cnt,
  input logic [NUM_ID-1:0]    id_bsy
);

  // Offered rid must be free when taken.
  grant_free: assert property (@(posedge clk) disable iff (rst)
    (map_req && map_vld) |-> !id_bsy[map_rid])
    else $error("rid %0d granted while busy", map_rid);

  free_match: assert property (@(posedge clk) disable iff (rst)
    int'(free_cnt) == NUM_ID - $countones(id_bsy))
    else $error("free count %0d disagrees with the busy map", free_cnt);

  // No offer only with a full pool. First cycle out of reset is exempt.
  offer_when_free: assert property (@(posedge clk) disable iff (rst)
    (!map_vld && !$past(rst)) |-> (&id_bsy))
    else $error("no offer although a rid is free");

endmodule

bind id_mapper id_remap_properties #(.NUM_ID(NUM_ID)) props_i (
  .clk      (clk),
  .rst      (rst),
  .map_req  (map_req),
  .map_vld  (map_vld),
  .map_rid  (map_rid),
  .free_cnt (free_cnt),
  .id_bsy   (id_bsy)
);

// ==== dv/id_remap_checker.sv ====
`timescale 1ns/1ps

module id_remap_checker #(
  parameter int NUM_ID = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req, req_grant, out_vld,
  input  logic                     rsp_0, rsp_1, rsp_vld_0, rsp_vld_1,
  input  logic                     lkp_vld, reg_wr, rd_chk,
  input  id_remap_pkg::id_t        req_fid, out_rid, out_fid,
  input  id_remap_pkg::id_t        rsp_rid_0, rsp_fid_0, rsp_rid_1, rsp_fid_1,
  input  id_remap_pkg::id_t        lkp_rid, lkp_fid,
  input  remap_reg_pkg::reg_addr_t reg_addr,
  input  remap_reg_pkg::reg_data_t reg_wdata, reg_rdata, rd_exp,
  output int                       err_model,
  output int                       err_file
);

  // Pool model.
  logic [NUM_ID-1:0] m_bsy;
  id_remap_pkg::id_t m_tbl [NUM_ID];
  int                m_last;       // Last granted rid, -1 out of reset.
  logic              m_offer_vld;
  int                m_offer;
  // Register model.
  logic              m_en;
  int                m_limit;
  int                m_grants;
  // Downstream request due next cycle.
  logic              grant_exp;
  logic              exp_out_vld;
  id_remap_pkg::id_t exp_out_rid;
  id_remap_pkg::id_t exp_out_fid;

  function automatic int free_count();
    return NUM_ID - $countones(m_bsy);
  endfunction

  function automatic remap_reg_pkg::reg_data_t reg_model(input remap_reg_pkg::reg_addr_t addr);
    case (addr)
      remap_reg_pkg::ADDR_CTRL:   return {15'd0, m_en};
      remap_reg_pkg::ADDR_LIMIT:  return 16'(m_limit);
      remap_reg_pkg::ADDR_FREE:   return 16'(free_count());
      remap_reg_pkg::ADDR_GRANTS: return 16'(m_grants);  // Wraps at 16 bits.
      remap_reg_pkg::ADDR_BUSY:   return 16'(m_bsy);
      default:                    return '0;
    endcase
  endfunction

  task automatic compare(input string name, input int unsigned exp, input int unsigned got);
    if (exp != got) begin
      $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
      err_model++;
    end
  endtask

  // Lowest free rid above the last grant, else lowest free overall.
  task automatic pick_offer();
    m_offer_vld = 1'b0;
    for (int i = NUM_ID - 1; i >= 0; i--)
      if (!m_bsy[i] && i > m_last) begin
        m_offer_vld = 1'b1;
        m_offer     = i;  // Descending, lowest wins.
      end
    if (!m_offer_vld)
      for (int i = NUM_ID - 1; i >= 0; i--)
        if (!m_bsy[i]) begin
          m_offer_vld = 1'b1;
          m_offer     = i;
        end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare the cycle that just ended, then advance the model.
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      m_bsy       = '0;
      m_last      = -1;
      m_offer_vld = 1'b0;
      m_offer     = 0;
      m_en        = 1'b0;
      m_limit     = NUM_ID;
      m_grants    = 0;
      exp_out_vld = 1'b0;
      err_model   = 0;
      err_file    = 0;
    end else begin
      grant_exp = req && m_en && m_offer_vld && (NUM_ID - free_count() < m_limit);
      compare("req_grant", grant_exp, req_grant);
      compare("out_vld", exp_out_vld, out_vld);
      if (exp_out_vld) begin
        compare("out_rid", exp_out_rid, out_rid);
        compare("out_fid", exp_out_fid, out_fid);
      end
      if (rsp_0) begin
        compare("rsp_vld_0", m_bsy[rsp_rid_0], rsp_vld_0);
        if (m_bsy[rsp_rid_0])
          compare("rsp_fid_0", m_tbl[rsp_rid_0], rsp_fid_0);
      end
      if (rsp_1) begin
        compare("rsp_vld_1", m_bsy[rsp_rid_1], rsp_vld_1);
        if (m_bsy[rsp_rid_1])
          compare("rsp_fid_1", m_tbl[rsp_rid_1], rsp_fid_1);
      end
      compare("lkp_vld", m_bsy[lkp_rid], lkp_vld);  // Lookup checked every cycle.
      if (m_bsy[lkp_rid])
        compare("lkp_fid", m_tbl[lkp_rid], lkp_fid);
      if (rd_chk) begin
        compare("reg_rdata", reg_model(reg_addr), reg_rdata);
        if (rd_exp != reg_rdata) begin
          $display("FAIL time=%0t reg_rdata(pattern) expected=%0h actual=%0h",
                   $time, rd_exp, reg_rdata);
          err_file++;
        end
      end
      // Model update.
      exp_out_vld = grant_exp;
      if (grant_exp) begin
        exp_out_rid = id_remap_pkg::id_t'(m_offer);
        exp_out_fid = req_fid;
      end
      if (rsp_0)
        m_bsy[rsp_rid_0] = 1'b0;
      if (rsp_1)
        m_bsy[rsp_rid_1] = 1'b0;
      if (grant_exp) begin
        m_bsy[m_offer] = 1'b1;
        m_tbl[m_offer] = req_fid;
        m_last         = m_offer;
        m_grants++;
      end
      if (reg_wr && reg_addr == remap_reg_pkg::ADDR_CTRL)
        m_en = reg_wdata[0];
      if (reg_wr && reg_addr == remap_reg_pkg::ADDR_LIMIT)
        m_limit = int'(reg_wdata[4:0]);
      if (reg_wr && reg_addr == remap_reg_pkg::ADDR_GRANTS)
        m_grants = 0;  // Clear wins over a grant.
      pick_offer();
    end
  end

endmodule

// ==== dv/id_remap_tb.sv ====
`timescale 1ns/1ps

module id_remap_tb;

  localparam int NUM_ID  = 16;
  localparam int PAT_MAX = 64;
  // Opcode in bits 31:28 of a pattern word.
  localparam logic [3:0] OP_REQ  = 4'h1;
  localparam logic [3:0] OP_FILL = 4'h2;  // Count of requests with random fids.
  localparam logic [3:0] OP_RSP  = 4'h3;
  localparam logic [3:0] OP_WR   = 4'h4;
  localparam logic [3:0] OP_RD   = 4'h5;
  localparam logic [3:0] OP_LKP  = 4'h6;
  localparam logic [3:0] OP_HOLD = 4'h7;  // Request expected to stay ungranted.
  localparam logic [3:0] OP_END  = 4'hF;

  logic                     clk = 1'b0;
  logic                     rst, req, req_grant, out_vld;
  logic                     rsp_0, rsp_1, rsp_vld_0, rsp_vld_1;
  logic                     lkp_vld, reg_wr, rd_chk;
  id_remap_pkg::id_t        req_fid, out_rid, out_fid, lkp_rid, lkp_fid;
  id_remap_pkg::id_t        rsp_rid_0, rsp_fid_0, rsp_rid_1, rsp_fid_1;
  remap_reg_pkg::reg_addr_t reg_addr;
  remap_reg_pkg::reg_data_t reg_wdata, reg_rdata, rd_exp;
  int                       err_model, err_file;
  logic [31:0]              pats [PAT_MAX];
  logic [31:0]              word;
  logic [31:0]              seed = 32'h5078;
  int                       n_pat = 0;
  int                       cycles = 0;
  int                       cycle_limit = 1000;

  id_remap_top #(.NUM_ID(NUM_ID)) dut_i (.*);
  id_remap_checker #(.NUM_ID(NUM_ID)) checker_i (.*);

  always #4 clk = ~clk;  // 8 ns.

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic clear_strobes();
    req    <= 1'b0;
    rsp_0  <= 1'b0;
    rsp_1  <= 1'b0;
    reg_wr <= 1'b0;
    rd_chk <= 1'b0;
  endtask

  // Hold the request until the grant is seen at an edge.
  task automatic request(input id_remap_pkg::id_t fid);
    req     <= 1'b1;
    req_fid <= fid;
    do @(posedge clk); while (!req_grant);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the pattern run did not finish", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    req = 1'b0;
    req_fid = '0;
    rsp_0 = 1'b0;
    rsp_1 = 1'b0;
    rsp_rid_0 = '0;
    rsp_rid_1 = '0;
    lkp_rid = '0;
    reg_wr = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    rd_chk = 1'b0;
    rd_exp = '0;
    for (int i = 0; i < PAT_MAX; i++)
      pats[i] = {OP_END, 28'(i)};  // Unloaded words end the run.
    $readmemh("dv/id_remap_patterns.txt", pats);
    while (n_pat < PAT_MAX && pats[n_pat][31:28] != OP_END)
      n_pat++;
    cycle_limit = 20 * n_pat + 200;

    repeat (8) @(posedge clk);
    rst <= 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // One operation per pattern word.
    ////////////////////////////////////////////////////////////////////////////
    for (int p = 0; p < n_pat; p++) begin
      word = pats[p];
      clear_strobes();
      case (word[31:28])
        OP_REQ:  request(word[3:0]);
        OP_FILL: repeat (word[7:0]) begin
          seed = lcg(seed);
          request(seed[19:16]);
        end
        OP_RSP: begin
          rsp_0     <= word[24];  // Port mask in 25:24.
          rsp_1     <= word[25];
          rsp_rid_0 <= word[3:0];
          rsp_rid_1 <= word[7:4];
          @(posedge clk);
        end
        OP_WR: begin
          reg_wr    <= 1'b1;
          reg_addr  <= word[26:24];
          reg_wdata <= word[15:0];
          @(posedge clk);
        end
        OP_RD: begin
          rd_chk   <= 1'b1;
          reg_addr <= word[26:24];
          rd_exp   <= word[15:0];
          @(posedge clk);
        end
        OP_LKP: begin
          lkp_rid <= word[3:0];
          @(posedge clk);
        end
        OP_HOLD: begin
          req     <= 1'b1;
          req_fid <= word[3:0];
          repeat (4) @(posedge clk);
        end
        default: @(posedge clk);  // Idle.
      endcase
    end
    clear_strobes();
    repeat (2) @(posedge clk);
    @(negedge clk);

    $display("Errors: %0d against the model, %0d against the patterns", err_model, err_file);
    if (err_model == 0 && err_file == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== dv/id_remap_patterns.txt ====
// Word: op[31:28] arg[26:24] data[15:0]. Ops 0 idle, 1 req fid, 2 fill count,
// 3 rsp mask/rid1/rid0, 4 write addr, 5 read addr expect, 6 lookup, 7 held req, F end.
50000000  // Enable reads 0.
51000010  // Limit 16.
70000003  // No grant while disabled.
40000001
1000000A  // Rid 0.
10000005  // Rid 1.
20000002  // Rids 2 and 3.
5200000C
53000004
60000001
31000000  // Release rid 0.
31000000  // Rid 0 again, not busy.
10000007  // Rotation gives rid 4.
5200000C
33000021  // Rids 1 and 2 together.
5200000E
41000003  // Limit 3.
10000009  // Rid 5.
70000006  // Three outstanding, held off.
32000030  // Port 1 frees rid 3.
10000006  // Rid 6.
41000010
53000007
43000000  // Clear grants.
53000000
2000000D  // Rids 7 to 15, then 0 to 3.
70000001  // Pool full.
5400FFFF
52000000
5300000D
60000004
52000000  // Lookup left the count alone.
33000098  // Rids 8 and 9.
52000002
40000000
70000002
50000000
00000000
F0000000

// ==== id_remap.f ====
source/id_remap_pkg.sv
source/remap_reg_pkg.sv
source/id_mapper.sv
source/req_remapper.sv
source/remap_regs.sv
source/id_remap_top.sv
dv/id_remap_properties.sv
dv/id_remap_checker.sv
dv/id_remap_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ID remapper testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module id_remap_tb \
  -f id_remap.f -o id_remap_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/id_remap_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
